/* design/mips_id_params.svh */
`ifndef MIPS_ID_PARAMS_SVH
`define MIPS_ID_PARAMS_SVH

// Datapath widths of the decode stage

`define NB_DATA 32  // Register and operand width

`define NB_INST 32  // Instruction word width

`define NB_PC 32    // Program counter width

`define NB_REG 5    // Register address width

`define N_REGS 32   // Register bank depth

`endif

/* design/mips_id_pkg.sv */
`include "mips_id_params.svh"

package mips_id_pkg;

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_LBU   = 6'h24,
        OP_LHU   = 6'h25,
        OP_LWU   = 6'h27,
        OP_SB    = 6'h28,
        OP_SH    = 6'h29,
        OP_SW    = 6'h2b,
        OP_HALT  = 6'h3f
    } opcode_e;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } funct_e;

    // Operation selected for the EX stage ALU
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,  // Zero so a bubble decodes as ADD
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_LUI = 4'd10
    } alu_op_e;

    // Control word, all zero is a bubble
    typedef struct packed {
        logic    reg_dest;     // EX, rd instead of rt
        logic    signed_op;
        alu_op_e alu_op;       // EX
        logic    alu_src;      // EX, immediate as operand B
        logic    mem_read;     // MEM
        logic    mem_write;    // MEM
        logic    branch;       // MEM
        logic    reg_write;    // WB
        logic    mem_to_reg;   // WB
        logic    jump;         // IF
        logic    jr_jalr;      // IF, target from operand A
        logic    byte_en;
        logic    halfword_en;
        logic    word_en;
    } id_ctrl_t;

    // Decoded instruction fields
    typedef struct packed {
        logic [`NB_REG-1:0]  rs;
        logic [`NB_REG-1:0]  rt;
        logic [`NB_REG-1:0]  rd;
        logic [`NB_PC-1:0]   pc;
        logic [`NB_DATA-1:0] immediate;
        logic [`NB_DATA-1:0] shamt;
        logic [`NB_PC-1:0]   jump_address;
    } id_fields_t;

endpackage

/* design/register_bank.sv */
`timescale 1ns/1ps

`include "mips_id_params.svh"

module register_bank (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  logic                i_enable,           // Debug unit write gate
    input  logic                i_reg_write,        // From WB
    input  logic [`NB_REG-1:0]  i_write_reg,        // From WB
    input  logic [`NB_DATA-1:0] i_write_data,       // From WB
    input  logic [`NB_REG-1:0]  i_read_reg_a,
    input  logic [`NB_REG-1:0]  i_read_reg_b,
    input  logic                i_dbg_read_enable,  // Debug unit strobe
    input  logic [`NB_REG-1:0]  i_dbg_read_addr,
    output logic [`NB_DATA-1:0] o_data_a,
    output logic [`NB_DATA-1:0] o_data_b,
    output logic [`NB_DATA-1:0] o_dbg_data
);

    logic [`NB_DATA-1:0] regs [`N_REGS];
    logic                wr_en;

    // Register 0 is never a write target
    assign wr_en = i_reg_write && i_enable && (i_write_reg != '0);

    // Read with write-through from the WB port
    function automatic logic [`NB_DATA-1:0] read_reg(input logic [`NB_REG-1:0] addr);
        logic [`NB_DATA-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en && (i_write_reg == addr)) begin
            value = i_write_data;  // Bypass
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    // Also follows the bank and the WB port read inside read_reg
    always_comb begin
        o_data_a = read_reg(i_read_reg_a);
        o_data_b = read_reg(i_read_reg_b);
    end

    // Debug value held until the next strobe
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dbg_data <= '0;
        end else if (i_dbg_read_enable) begin
            o_dbg_data <= read_reg(i_dbg_read_addr);
        end
    end

endmodule

/* design/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    input  logic                   i_enable,    // Debug unit
    input  logic                   i_ctrl_sel,  // Stall unit flush
    input  mips_id_pkg::opcode_e   i_opcode,
    input  mips_id_pkg::funct_e    i_funct,
    output mips_id_pkg::id_ctrl_t  o_ctrl,
    output logic                   o_hlt
);

    import mips_id_pkg::*;

    id_ctrl_t ctrl_dec;
    logic     active;

    assign active = i_enable && !i_ctrl_sel;

    always_comb begin
        ctrl_dec = '0;
        case (i_opcode)
            OP_RTYPE: begin
                ctrl_dec.reg_dest  = 1'b1;
                ctrl_dec.reg_write = 1'b1;
                case (i_funct)
                    FN_SLL, FN_SLLV: ctrl_dec.alu_op = ALU_SLL;
                    FN_SRL, FN_SRLV: ctrl_dec.alu_op = ALU_SRL;
                    FN_SRA, FN_SRAV: ctrl_dec.alu_op = ALU_SRA;
                    FN_ADDU:         ctrl_dec.alu_op = ALU_ADD;
                    FN_SUBU:         ctrl_dec.alu_op = ALU_SUB;
                    FN_AND:          ctrl_dec.alu_op = ALU_AND;
                    FN_OR:           ctrl_dec.alu_op = ALU_OR;
                    FN_XOR:          ctrl_dec.alu_op = ALU_XOR;
                    FN_NOR:          ctrl_dec.alu_op = ALU_NOR;
                    FN_SLT: begin
                        ctrl_dec.alu_op    = ALU_SLT;
                        ctrl_dec.signed_op = 1'b1;
                    end
                    FN_JR: begin
                        // No register written
                        ctrl_dec.reg_dest  = 1'b0;
                        ctrl_dec.reg_write = 1'b0;
                        ctrl_dec.jump      = 1'b1;
                        ctrl_dec.jr_jalr   = 1'b1;
                    end
                    FN_JALR: begin
                        ctrl_dec.jump    = 1'b1;
                        ctrl_dec.jr_jalr = 1'b1;  // Link goes to rd
                    end
                    default: ctrl_dec = '0;  // Unknown funct
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI: begin
                ctrl_dec.alu_src   = 1'b1;
                ctrl_dec.reg_write = 1'b1;
                ctrl_dec.signed_op = 1'b1;
                ctrl_dec.alu_op    = (i_opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_dec.alu_src   = 1'b1;
                ctrl_dec.reg_write = 1'b1;
                case (i_opcode)
                    OP_ANDI: ctrl_dec.alu_op = ALU_AND;
                    OP_ORI:  ctrl_dec.alu_op = ALU_OR;
                    OP_XORI: ctrl_dec.alu_op = ALU_XOR;
                    default: ctrl_dec.alu_op = ALU_LUI;
                endcase
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                ctrl_dec.mem_read   = 1'b1;
                ctrl_dec.mem_to_reg = 1'b1;
                ctrl_dec.reg_write  = 1'b1;
                ctrl_dec.alu_src    = 1'b1;
                ctrl_dec.alu_op     = ALU_ADD;  // Base plus offset
                ctrl_dec.signed_op  = (i_opcode == OP_LB) || (i_opcode == OP_LH);
                ctrl_dec.byte_en    = (i_opcode == OP_LB) || (i_opcode == OP_LBU);
                ctrl_dec.halfword_en = (i_opcode == OP_LH) || (i_opcode == OP_LHU);
                ctrl_dec.word_en    = (i_opcode == OP_LW) || (i_opcode == OP_LWU);
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl_dec.mem_write   = 1'b1;
                ctrl_dec.alu_src     = 1'b1;
                ctrl_dec.alu_op      = ALU_ADD;
                ctrl_dec.byte_en     = (i_opcode == OP_SB);
                ctrl_dec.halfword_en = (i_opcode == OP_SH);
                ctrl_dec.word_en     = (i_opcode == OP_SW);
            end
            OP_BEQ, OP_BNE: begin
                ctrl_dec.branch = 1'b1;
                ctrl_dec.alu_op = ALU_SUB;  // Compare by subtraction
            end
            OP_J: begin
                ctrl_dec.jump = 1'b1;
            end
            OP_JAL: begin
                ctrl_dec.jump      = 1'b1;
                ctrl_dec.reg_write = 1'b1;  // Link to r31
            end
            default: ctrl_dec = '0;  // HALT and unknown opcodes
        endcase
    end

    // Flush or disable gives a bubble
    assign o_ctrl = active ? ctrl_dec : '0;

    // Sticky until reset
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_hlt <= 1'b0;
        end else if (active && (i_opcode == OP_HALT)) begin
            o_hlt <= 1'b1;
        end
    end

endmodule

/* design/field_extract.sv */
`timescale 1ns/1ps

`include "mips_id_params.svh"

module field_extract (
    input  logic [`NB_INST-1:0]       i_inst,
    input  logic [`NB_PC-1:0]         i_pc,
    output mips_id_pkg::id_fields_t   o_fields
);

    always_comb begin
        o_fields.rs = i_inst[25:21];
        o_fields.rt = i_inst[20:16];
        o_fields.rd = i_inst[15:11];
        o_fields.pc = i_pc;

        // Immediate or function code, sign extended
        o_fields.immediate = {{(`NB_DATA-16){i_inst[15]}}, i_inst[15:0]};

        o_fields.shamt = {{(`NB_DATA-5){1'b0}}, i_inst[10:6]};

        // Region bits of PC with the word target
        o_fields.jump_address = {i_pc[`NB_PC-1:`NB_PC-4], i_inst[25:0], 2'b00};
    end

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ps

`include "mips_id_params.svh"

module id_stage (
    input  logic                       i_clock,
    input  logic                       i_rst_n,
    input  logic                       i_cu_enable,        // Debug unit
    input  logic                       i_rb_enable,        // Debug unit
    input  logic                       i_dbg_read_enable,  // Debug unit
    input  logic [`NB_REG-1:0]         i_dbg_read_addr,    // Debug unit
    input  logic [`NB_INST-1:0]        i_inst,
    input  logic [`NB_PC-1:0]          i_pc,
    input  logic [`NB_DATA-1:0]        i_wb_data,          // From WB
    input  logic [`NB_REG-1:0]         i_wb_reg,           // From WB
    input  logic                       i_wb_reg_write,     // From WB
    input  logic                       i_ctrl_sel,         // Stall unit flush
    output mips_id_pkg::id_ctrl_t      o_ctrl,
    output logic                       o_hlt,
    output mips_id_pkg::id_fields_t    o_fields,
    output logic [`NB_DATA-1:0]        o_data_a,
    output logic [`NB_DATA-1:0]        o_data_b,
    output logic [`NB_DATA-1:0]        o_dbg_data
);

    import mips_id_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(i_inst[31:26]);
    assign funct  = funct_e'(i_inst[5:0]);

    register_bank u_register_bank (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_enable          (i_rb_enable),
        .i_reg_write       (i_wb_reg_write),
        .i_write_reg       (i_wb_reg),
        .i_write_data      (i_wb_data),
        .i_read_reg_a      (i_inst[25:21]),  // rs
        .i_read_reg_b      (i_inst[20:16]),  // rt
        .i_dbg_read_enable (i_dbg_read_enable),
        .i_dbg_read_addr   (i_dbg_read_addr),
        .o_data_a          (o_data_a),
        .o_data_b          (o_data_b),
        .o_dbg_data        (o_dbg_data)
    );

    control_unit u_control_unit (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_enable   (i_cu_enable),
        .i_ctrl_sel (i_ctrl_sel),
        .i_opcode   (opcode),
        .i_funct    (funct),
        .o_ctrl     (o_ctrl),
        .o_hlt      (o_hlt)
    );

    field_extract u_field_extract (
        .i_inst   (i_inst),
        .i_pc     (i_pc),
        .o_fields (o_fields)
    );

endmodule

/* tests/tb_id_stage.sv */
`timescale 1ns/1ps

`include "mips_id_params.svh"

module tb_id_stage;

    import mips_id_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam logic [31:0] SEED         = 32'h300c_5378;
    localparam int          N_RTYPE      = 64;
    localparam int          N_ITYPE      = 72;
    localparam int          N_REGFILE    = 120;
    localparam int          N_FLUSH      = 48;
    localparam int          N_JUMP       = 48;
    localparam int          N_DEBUG      = 60;
    localparam int          N_AFTER      = 16;
    localparam int          TOTAL_CYCLES = 2 + N_RTYPE + N_ITYPE + N_REGFILE + N_FLUSH
                                         + N_JUMP + 1 + N_DEBUG + 2 + N_AFTER;
    localparam int          WATCHDOG_NS  = (TOTAL_CYCLES + 50) * CLK_PERIOD;

    localparam logic [5:0] FUNCTS [16] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, 6'h3e  // Last is undefined
    };
    localparam logic [5:0] ITYPE_OPS [18] = '{
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH,
        OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE
    };

    logic                i_clock;
    logic                i_rst_n;
    logic                i_cu_enable;
    logic                i_rb_enable;
    logic                i_dbg_read_enable;
    logic [`NB_REG-1:0]  i_dbg_read_addr;
    logic [`NB_INST-1:0] i_inst;
    logic [`NB_PC-1:0]   i_pc;
    logic [`NB_DATA-1:0] i_wb_data;
    logic [`NB_REG-1:0]  i_wb_reg;
    logic                i_wb_reg_write;
    logic                i_ctrl_sel;
    id_ctrl_t            o_ctrl;
    logic                o_hlt;
    id_fields_t          o_fields;
    logic [`NB_DATA-1:0] o_data_a;
    logic [`NB_DATA-1:0] o_data_b;
    logic [`NB_DATA-1:0] o_dbg_data;

    // Reference model state
    logic [`NB_DATA-1:0] shadow [`N_REGS];
    logic                wb_active;
    id_ctrl_t            exp_ctrl;
    id_fields_t          exp_fields;
    logic [`NB_DATA-1:0] exp_data_a;
    logic [`NB_DATA-1:0] exp_data_b;
    logic [`NB_DATA-1:0] exp_dbg_next;
    logic [`NB_DATA-1:0] exp_dbg;
    logic                exp_hlt;

    id_stage u_dut (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_cu_enable       (i_cu_enable),
        .i_rb_enable       (i_rb_enable),
        .i_dbg_read_enable (i_dbg_read_enable),
        .i_dbg_read_addr   (i_dbg_read_addr),
        .i_inst            (i_inst),
        .i_pc              (i_pc),
        .i_wb_data         (i_wb_data),
        .i_wb_reg          (i_wb_reg),
        .i_wb_reg_write    (i_wb_reg_write),
        .i_ctrl_sel        (i_ctrl_sel),
        .o_ctrl            (o_ctrl),
        .o_hlt             (o_hlt),
        .o_fields          (o_fields),
        .o_data_a          (o_data_a),
        .o_data_b          (o_data_b),
        .o_dbg_data        (o_dbg_data)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // Expected control word from the decode rules
    function automatic id_ctrl_t expected_ctrl(input logic [31:0] inst, input logic active);
        id_ctrl_t   c;
        logic [5:0] op;
        logic [5:0] fn;
        c  = '0;
        op = inst[31:26];
        fn = inst[5:0];
        if (active) begin
            case (op)
                OP_RTYPE: begin
                    c.reg_dest  = (fn != FN_JR);
                    c.reg_write = (fn != FN_JR);
                    c.jump      = (fn == FN_JR) || (fn == FN_JALR);
                    c.jr_jalr   = c.jump;
                    c.signed_op = (fn == FN_SLT);
                    case (fn)
                        FN_SLL, FN_SLLV: c.alu_op = ALU_SLL;
                        FN_SRL, FN_SRLV: c.alu_op = ALU_SRL;
                        FN_SRA, FN_SRAV: c.alu_op = ALU_SRA;
                        FN_SUBU:         c.alu_op = ALU_SUB;
                        FN_AND:          c.alu_op = ALU_AND;
                        FN_OR:           c.alu_op = ALU_OR;
                        FN_XOR:          c.alu_op = ALU_XOR;
                        FN_NOR:          c.alu_op = ALU_NOR;
                        FN_SLT:          c.alu_op = ALU_SLT;
                        FN_ADDU, FN_JR, FN_JALR: c.alu_op = ALU_ADD;
                        default:         c = '0;  // Undefined funct is a bubble
                    endcase
                end
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    c.alu_src   = 1'b1;
                    c.reg_write = 1'b1;
                    c.signed_op = (op == OP_ADDI) || (op == OP_ADDIU) || (op == OP_SLTI);
                    case (op)
                        OP_SLTI: c.alu_op = ALU_SLT;
                        OP_ANDI: c.alu_op = ALU_AND;
                        OP_ORI:  c.alu_op = ALU_OR;
                        OP_XORI: c.alu_op = ALU_XOR;
                        OP_LUI:  c.alu_op = ALU_LUI;
                        default: c.alu_op = ALU_ADD;
                    endcase
                end
                OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_SB, OP_SH, OP_SW: begin
                    c.alu_src     = 1'b1;
                    c.mem_read    = !op[3];  // Stores have bit 3 set
                    c.mem_to_reg  = !op[3];
                    c.reg_write   = !op[3];
                    c.mem_write   = op[3];
                    c.signed_op   = (op == OP_LB) || (op == OP_LH);
                    c.byte_en     = (op == OP_LB) || (op == OP_LBU) || (op == OP_SB);
                    c.halfword_en = (op == OP_LH) || (op == OP_LHU) || (op == OP_SH);
                    c.word_en     = (op == OP_LW) || (op == OP_LWU) || (op == OP_SW);
                end
                OP_BEQ, OP_BNE: begin
                    c.branch = 1'b1;
                    c.alu_op = ALU_SUB;
                end
                OP_J, OP_JAL: begin
                    c.jump      = 1'b1;
                    c.reg_write = (op == OP_JAL);
                end
                default: c = '0;
            endcase
        end
        return c;
    endfunction

    // Bank read with write-through
    function automatic logic [31:0] bank_read(input logic [4:0] addr, input logic [31:0] stored);
        logic [31:0] value;
        value = stored;
        if (wb_active && (i_wb_reg == addr)) begin
            value = i_wb_data;
        end
        if (addr == 5'd0) begin
            value = '0;
        end
        return value;
    endfunction

    assign wb_active = i_wb_reg_write && i_rb_enable && (i_wb_reg != 5'd0);

    always_comb begin
        exp_ctrl                = expected_ctrl(i_inst, i_cu_enable && !i_ctrl_sel);
        exp_fields.rs           = i_inst[25:21];
        exp_fields.rt           = i_inst[20:16];
        exp_fields.rd           = i_inst[15:11];
        exp_fields.pc           = i_pc;
        exp_fields.immediate    = {{16{i_inst[15]}}, i_inst[15:0]};
        exp_fields.shamt        = {27'd0, i_inst[10:6]};
        exp_fields.jump_address = {i_pc[31:28], i_inst[25:0], 2'b00};
        exp_data_a              = bank_read(i_inst[25:21], shadow[i_inst[25:21]]);
        exp_data_b              = bank_read(i_inst[20:16], shadow[i_inst[20:16]]);
        exp_dbg_next            = bank_read(i_dbg_read_addr, shadow[i_dbg_read_addr]);
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `N_REGS; i++) begin
                shadow[i] <= '0;
            end
            exp_hlt <= 1'b0;
            exp_dbg <= '0;
        end else begin
            if (wb_active) begin
                shadow[i_wb_reg] <= i_wb_data;
            end
            if (i_cu_enable && !i_ctrl_sel && (i_inst[31:26] == OP_HALT)) begin
                exp_hlt <= 1'b1;  // Sticky
            end
            if (i_dbg_read_enable) begin
                exp_dbg <= exp_dbg_next;
            end
        end
    end

    task automatic report_mismatch(input string what, input string got, input string exp);
        $display("Error at %0d ns: %s is %s, expected %s", $time, what, got, exp);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    a_ctrl: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_ctrl == exp_ctrl)
        else report_mismatch("o_ctrl", $sformatf("%h", o_ctrl), $sformatf("%h", exp_ctrl));
    a_fields: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_fields == exp_fields)
        else report_mismatch("o_fields", $sformatf("%h", o_fields), $sformatf("%h", exp_fields));
    a_data_a: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_data_a == exp_data_a)
        else report_mismatch("o_data_a", $sformatf("%h", o_data_a), $sformatf("%h", exp_data_a));
    a_data_b: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_data_b == exp_data_b)
        else report_mismatch("o_data_b", $sformatf("%h", o_data_b), $sformatf("%h", exp_data_b));
    a_hlt: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_hlt == exp_hlt)
        else report_mismatch("o_hlt", $sformatf("%b", o_hlt), $sformatf("%b", exp_hlt));
    a_dbg: assert property (@(posedge i_clock) disable iff (!i_rst_n) o_dbg_data == exp_dbg)
        else report_mismatch("o_dbg_data", $sformatf("%h", o_dbg_data), $sformatf("%h", exp_dbg));

    function automatic logic [4:0] rand_reg();
        return 5'($urandom());
    endfunction

    function automatic logic [31:0] rtype_inst(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [5:0] fn);
        return {6'h00, rs, rt, rand_reg(), rand_reg(), fn};
    endfunction

    function automatic logic [31:0] itype_inst(input logic [5:0] op);
        return {op, rand_reg(), rand_reg(), 16'($urandom())};
    endfunction

    task automatic next_cycle();
        @(negedge i_clock);
    endtask

    task automatic apply_reset();
        i_rst_n = 1'b0;
        repeat (2) next_cycle();
        i_rst_n = 1'b1;
    endtask

    task automatic random_writeback();
        i_wb_reg       = rand_reg();
        i_wb_data      = $urandom();
        i_wb_reg_write = ($urandom_range(0, 3) != 0);
    endtask

    task automatic run_decode();
        for (int i = 0; i < N_RTYPE; i++) begin
            i_inst = rtype_inst(rand_reg(), rand_reg(), FUNCTS[i % 16]);
            i_pc   = $urandom();
            random_writeback();
            next_cycle();
        end
        for (int i = 0; i < N_ITYPE; i++) begin
            i_inst = itype_inst(ITYPE_OPS[i % 18]);
            i_pc   = $urandom();
            random_writeback();
            next_cycle();
        end
    endtask

    task automatic run_regfile();
        logic [4:0] target;
        for (int i = 0; i < N_REGFILE; i++) begin
            target = (i % 10 == 0) ? 5'd0 : rand_reg();
            random_writeback();
            i_wb_reg    = target;
            i_rb_enable = ($urandom_range(0, 4) != 0);
            case (i % 4)
                0:       i_inst = rtype_inst(target, rand_reg(), FN_ADDU);  // Bypass on A
                1:       i_inst = rtype_inst(rand_reg(), target, FN_ADDU);  // Bypass on B
                2:       i_inst = rtype_inst(5'd0, rand_reg(), FN_ADDU);
                default: i_inst = rtype_inst(rand_reg(), rand_reg(), FN_ADDU);
            endcase
            next_cycle();
        end
        i_rb_enable = 1'b1;
    endtask

    task automatic run_flush();
        for (int i = 0; i < N_FLUSH; i++) begin
            i_ctrl_sel  = (i % 3 != 1);
            i_cu_enable = (i % 3 == 0);
            if (i % 4 == 0) begin
                i_inst = {OP_HALT, 26'($urandom())};  // Must not halt
            end else if (i % 4 == 1) begin
                i_inst = rtype_inst(rand_reg(), rand_reg(), FUNCTS[i % 15]);
            end else begin
                i_inst = itype_inst(ITYPE_OPS[i % 18]);
            end
            random_writeback();
            next_cycle();
        end
        i_ctrl_sel  = 1'b0;
        i_cu_enable = 1'b1;
    endtask

    task automatic run_jumps();
        for (int i = 0; i < N_JUMP; i++) begin
            case (i % 4)
                0:       i_inst = {OP_J, 26'($urandom())};
                1:       i_inst = {OP_JAL, 26'($urandom())};
                2:       i_inst = rtype_inst(rand_reg(), rand_reg(), FN_JR);
                default: i_inst = rtype_inst(rand_reg(), rand_reg(), FN_JALR);
            endcase
            i_pc = $urandom();
            random_writeback();
            next_cycle();
        end
    endtask

    task automatic run_halt_debug();
        i_inst = {OP_HALT, 26'($urandom())};
        next_cycle();
        for (int i = 0; i < N_DEBUG; i++) begin
            i_inst            = itype_inst(ITYPE_OPS[i % 18]);
            i_dbg_read_enable = (i % 3 == 0);  // Value must hold between strobes
            i_dbg_read_addr   = rand_reg();
            random_writeback();
            next_cycle();
        end
        i_dbg_read_enable = 1'b0;
        apply_reset();  // Only way to clear halt
        for (int i = 0; i < N_AFTER; i++) begin
            i_inst = rtype_inst(rand_reg(), rand_reg(), FUNCTS[i % 15]);
            next_cycle();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(SEED));
        i_clock           = 1'b0;
        i_rst_n           = 1'b0;
        i_cu_enable       = 1'b1;
        i_rb_enable       = 1'b1;
        i_dbg_read_enable = 1'b0;
        i_dbg_read_addr   = '0;
        i_inst            = '0;
        i_pc              = '0;
        i_wb_data         = '0;
        i_wb_reg          = '0;
        i_wb_reg_write    = 1'b0;
        i_ctrl_sel        = 1'b0;
        repeat (2) next_cycle();
        i_rst_n = 1'b1;
        run_decode();
        run_regfile();
        run_flush();
        run_jumps();
        run_halt_debug();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/mips_id_pkg.sv
design/register_bank.sv
design/control_unit.sv
design/field_extract.sv
design/id_stage.sv
tests/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the ID stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_stage -f verilog.f -o tb_id_stage \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_id_stage)
echo "$out"
echo "$out" | grep -q "^Simulation PASSED$" && echo "Run passed" \
    || { echo "Run failed"; exit 1; }
